// File: files.f
conv_pkg.sv
conv_ctrl.sv
patch_addr_gen.sv
pixel_ram.sv
patch_window.sv
mac_unit.sv
conv_top.sv
conv_tb.sv

// File: conv_tb.sv
module conv_tb import conv_pkg::*;
();

    logic                    clk;
    logic                    rst;
    logic                    pix_we;
    logic [ADDR_W-1:0]       pix_waddr;
    logic [PIX_W-1:0]        pix_wdata;
    logic                    w_we;
    logic [IDX_W-1:0]        w_idx;
    logic signed [WGT_W-1:0] w_data;
    logic                    start;
    logic                    busy;
    logic                    result_valid;
    logic signed [ACC_W-1:0] result_value;
    logic                    done;

    // the testbench's own copy of the image and the kernel
    int img_ref [NUM_PIX];
    int wgt_ref [TAPS];

    // 17-bit Fibonacci register with the polynomial x^17 + x^14 + 1
    logic [16:0] lfsr;

    // bookkeeping of the result monitor
    logic run_active;
    logic full_ones_mode;
    int   ncyc;
    int   pcyc;
    int   start_cyc;
    int   res_cnt;
    int   runs_done;

    conv_top u_dut
    (
        .clk          (clk),
        .rst          (rst),
        .pix_we       (pix_we),
        .pix_waddr    (pix_waddr),
        .pix_wdata    (pix_wdata),
        .w_we         (w_we),
        .w_idx        (w_idx),
        .w_data       (w_data),
        .start        (start),
        .busy         (busy),
        .result_valid (result_valid),
        .result_value (result_value),
        .done         (done)
    );

    always #50 clk = ~clk;

    task automatic report_failure;
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // one step of the shift register where the new bit enters at the bottom
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // each bit of the byte costs one step of the register
    task automatic draw_byte(output logic [7:0] v);
        for (int b = 0; b < 8; b++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    // zero padded dilated sum where tap k sits DIL*(k mod 3)-PAD rows
    // and DIL*(k div 3)-PAD columns away
    function automatic int conv_ref(input int i, input int j);
        int sum;
        int r;
        int c;
        sum = 0;
        for (int k = 0; k < TAPS; k++)
        begin
            r = i + DIL * (k % K) - PAD;
            c = j + DIL * (k / K) - PAD;
            if (r >= 0 && r < IMG_H && c >= 0 && c < IMG_W)
            begin
                sum = sum + img_ref[r * IMG_W + c] * wgt_ref[k];
            end
        end
        return sum;
    endfunction

    // number of taps of position (i,j) that land inside the image
    function automatic int taps_inside(input int i, input int j);
        int n;
        int r;
        int c;
        n = 0;
        for (int k = 0; k < TAPS; k++)
        begin
            r = i + DIL * (k % K) - PAD;
            c = j + DIL * (k / K) - PAD;
            if (r >= 0 && r < IMG_H && c >= 0 && c < IMG_W)
            begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    task automatic check_level(input string name, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            report_failure();
        end
    endtask

    // result number n belongs to output position (n div 28, n mod 28)
    task automatic check_result(input int n);
        int i;
        int j;
        int exp;
        i = n / IMG_W;
        j = n % IMG_W;
        // with all pixels 255 and all weights -128 each inside tap adds -32640
        if (full_ones_mode)
            exp = -32640 * taps_inside(i, j);
        else
            exp = conv_ref(i, j);
        assert (int'(result_value) == exp)
        else
        begin
            $display("MISMATCH result_value at row %0d col %0d: got %h expected %h",
                     i, j, result_value, ACC_W'(exp));
            report_failure();
        end
    endtask

    // outputs change at the rising edge, so the monitor looks at them on the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            ncyc = ncyc + 1;
            if (!run_active)
            begin
                check_level("busy", busy, 1'b0);
                check_level("done", done, 1'b0);
                check_level("result_valid", result_valid, 1'b0);
                // start seen now is taken at the next rising edge
                if (start)
                begin
                    run_active = 1'b1;
                    start_cyc = ncyc;
                    res_cnt = 0;
                end
            end
            else if (res_cnt < NUM_PIX)
            begin
                check_level("busy", busy, 1'b1);
                check_level("done", done, 1'b0);
                // one cycle for the controller, then five pipeline stages
                if (ncyc < start_cyc + 6)
                begin
                    check_level("result_valid", result_valid, 1'b0);
                end
                else
                begin
                    check_level("result_valid", result_valid, 1'b1);
                    check_result(res_cnt);
                    res_cnt = res_cnt + 1;
                end
            end
            else
            begin
                // the cycle right after the last result
                check_level("done", done, 1'b1);
                check_level("busy", busy, 1'b0);
                check_level("result_valid", result_valid, 1'b0);
                run_active = 1'b0;
                runs_done = runs_done + 1;
            end
        end
    end

    // limit is two loads, two runs with their pipeline fill and a generous margin
    always @(posedge clk)
    begin
        pcyc = pcyc + 1;
        if (pcyc > 2 * (NUM_PIX + TAPS) + 2 * (NUM_PIX + PIPE_LAT + 10) + 1800)
        begin
            $display("timeout, the runs did not complete within the cycle limit");
            report_failure();
        end
    end

    // all inputs move a short delay after the rising edge
    task automatic next_slot;
        @(posedge clk);
        #10;
    endtask

    task automatic write_pixel(input int a, input int v);
        pix_we = 1'b1;
        pix_waddr = ADDR_W'(a);
        pix_wdata = PIX_W'(v);
        img_ref[a] = v;
        next_slot();
        pix_we = 1'b0;
    endtask

    task automatic write_weight(input int k, input int v);
        w_we = 1'b1;
        w_idx = IDX_W'(k);
        w_data = WGT_W'(v);
        wgt_ref[k] = v;
        next_slot();
        w_we = 1'b0;
    endtask

    task automatic pulse_start;
        start = 1'b1;
        next_slot();
        start = 1'b0;
    endtask

    initial
    begin
        logic [7:0] b;
        clk = 1'b0;
        rst = 1'b0;
        pix_we = 1'b0;
        pix_waddr = '0;
        pix_wdata = '0;
        w_we = 1'b0;
        w_idx = '0;
        w_data = '0;
        start = 1'b0;
        lfsr = 17'd72609;
        run_active = 1'b0;
        full_ones_mode = 1'b0;
        ncyc = 0;
        pcyc = 0;
        start_cyc = 0;
        res_cnt = 0;
        runs_done = 0;

        repeat (5) @(posedge clk);
        #10;
        rst = 1'b1;
        // idle cycles let the monitor see the quiet outputs after reset
        repeat (4) next_slot();

        // run 1 uses a random image and random kernel
        for (int a = 0; a < NUM_PIX; a++)
        begin
            draw_byte(b);
            write_pixel(a, int'(b));
        end
        for (int k = 0; k < TAPS; k++)
        begin
            draw_byte(b);
            write_weight(k, int'($signed(b)));
        end
        next_slot();
        pulse_start();

        // a second start halfway through must be ignored
        while (res_cnt < NUM_PIX / 2)
            @(posedge clk);
        #10;
        pulse_start();

        while (runs_done < 1)
            @(posedge clk);
        #10;
        repeat (3) next_slot();

        // run 2 takes the largest magnitude of every product
        full_ones_mode = 1'b1;
        for (int a = 0; a < NUM_PIX; a++)
        begin
            write_pixel(a, 255);
        end
        for (int k = 0; k < TAPS; k++)
        begin
            write_weight(k, -128);
        end
        next_slot();
        pulse_start();

        while (runs_done < 2)
            @(posedge clk);
        #10;
        repeat (3) next_slot();

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: conv_top.sv
module conv_top import conv_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pix_we,
    input  logic [ADDR_W-1:0]       pix_waddr,
    input  logic [PIX_W-1:0]        pix_wdata,
    input  logic                    w_we,
    input  logic [IDX_W-1:0]        w_idx,
    input  logic signed [WGT_W-1:0] w_data,
    input  logic                    start,
    output logic                    busy,
    output logic                    result_valid,
    output logic signed [ACC_W-1:0] result_value,
    output logic                    done
);

    // scan position from the controller
    logic addr_strobe;
    logic [COORD_W-1:0] row;
    logic [COORD_W-1:0] col;

    // pipeline between the datapath stages, each valid travels with its payload
    logic req_valid;
    patch_req_t req;
    logic rd_valid;
    patch_pix_t rd;
    logic win_valid;
    window_t win;

    conv_ctrl u_ctrl
    (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .busy        (busy),
        .done        (done),
        .addr_strobe (addr_strobe),
        .row         (row),
        .col         (col)
    );

    patch_addr_gen u_addr
    (
        .clk         (clk),
        .rst         (rst),
        .addr_strobe (addr_strobe),
        .row         (row),
        .col         (col),
        .req_valid   (req_valid),
        .req         (req)
    );

    pixel_ram u_ram
    (
        .clk       (clk),
        .rst       (rst),
        .pix_we    (pix_we),
        .req_valid (req_valid),
        .busy      (busy),
        .pix_waddr (pix_waddr),
        .pix_wdata (pix_wdata),
        .req       (req),
        .rd_valid  (rd_valid),
        .rd        (rd)
    );

    patch_window u_win
    (
        .clk       (clk),
        .rst       (rst),
        .rd_valid  (rd_valid),
        .rd        (rd),
        .win_valid (win_valid),
        .win       (win)
    );

    mac_unit u_mac
    (
        .clk          (clk),
        .rst          (rst),
        .w_we         (w_we),
        .win_valid    (win_valid),
        .w_idx        (w_idx),
        .w_data       (w_data),
        .win          (win),
        .result_valid (result_valid),
        .result_value (result_value)
    );

endmodule

// File: mac_unit.sv
module mac_unit import conv_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    w_we,
    input  logic                    win_valid,
    input  logic [IDX_W-1:0]        w_idx,
    input  logic signed [WGT_W-1:0] w_data,
    input  window_t                 win,
    output logic                    result_valid,
    output logic signed [ACC_W-1:0] result_value
);

    logic signed [WGT_W-1:0] wgt [TAPS];
    logic signed [PROD_W-1:0] prod [TAPS];
    logic signed [ACC_W-1:0] sum;
    logic prod_valid;

    // weight bank, written by tap index
    always_ff @(posedge clk)
    begin
        if (w_we)
        begin
            wgt[w_idx] <= w_data;
        end
    end

    // first stage registers the nine products
    // the pixel gets a zero sign bit so that 255 stays positive
    always_ff @(posedge clk)
    begin
        if (win_valid)
        begin
            for (int k = 0; k < TAPS; k++)
            begin
                prod[k] <= $signed({1'b0, win.pix[k]}) * wgt[k];
            end
        end
    end

    // adder tree over the registered products
    // every operand is signed, so each product is sign extended to the full width
    always_comb
    begin
        sum = '0;
        for (int k = 0; k < TAPS; k++)
        begin
            sum = sum + prod[k];
        end
    end

    // second stage registers the sum
    always_ff @(posedge clk)
    begin
        if (prod_valid)
        begin
            result_value <= sum;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            prod_valid <= 1'b0;
            result_valid <= 1'b0;
        end
        else
        begin
            prod_valid <= win_valid;
            result_valid <= prod_valid;
        end
    end

    assert property (@(posedge clk) disable iff (!rst) w_we |-> w_idx < TAPS)
        else $error("weight index outside the kernel");

    // a weight changing while a window is in the MAC would mix two kernels in one sum
    assert property (@(posedge clk) disable iff (!rst) w_we |-> !win_valid && !prod_valid)
        else $error("weight write while the MAC holds data");

endmodule

// File: patch_window.sv
module patch_window import conv_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rd_valid,
    input  patch_pix_t rd,
    output logic       win_valid,
    output window_t    win
);

    // five columns from j-2 to j+2 relative to the current output column, three rows each
    // with dilation two, neighbouring positions share no kernel column, so the window keeps
    // the columns in between for the position after next
    logic [HIST_COLS-1:0][K-1:0][PIX_W-1:0] hist;

    always_ff @(posedge clk)
    begin
        if (rd_valid)
        begin
            // every step moves the history one column to the left
            for (int c = 0; c < HIST_COLS - 1; c++)
            begin
                hist[c] <= hist[c + 1];
            end
            // the freshly fetched right column enters at the far right
            for (int r = 0; r < K; r++)
            begin
                hist[HIST_COLS-1][r] <= rd.pix[2 * K + r];
            end
            // on a full read the left and middle kernel columns replace whatever shifted in
            if (rd.full)
            begin
                for (int r = 0; r < K; r++)
                begin
                    hist[0][r] <= rd.pix[r];
                    hist[DIL][r] <= rd.pix[K + r];
                end
            end
        end
    end

    // the kernel sees every second history column
    always_comb
    begin
        for (int c = 0; c < K; c++)
        begin
            for (int r = 0; r < K; r++)
            begin
                win.pix[c * K + r] = hist[c * DIL][r];
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            win_valid <= 1'b0;
        end
        else
        begin
            win_valid <= rd_valid;
        end
    end

endmodule

// File: pixel_ram.sv
module pixel_ram import conv_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              pix_we,
    input  logic              req_valid,
    input  logic              busy,
    input  logic [ADDR_W-1:0] pix_waddr,
    input  logic [PIX_W-1:0]  pix_wdata,
    input  patch_req_t        req,
    output logic              rd_valid,
    output patch_pix_t        rd
);

    logic [PIX_W-1:0] mem [NUM_PIX];

    // single write port used while loading the image
    always_ff @(posedge clk)
    begin
        if (pix_we)
        begin
            mem[pix_waddr] <= pix_wdata;
        end
    end

    // nine registered reads per request
    // padding taps come back as zero so the MAC needs no knowledge of the border
    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            for (int k = 0; k < TAPS; k++)
            begin
                rd.pix[k] <= req.taps[k].in_img ? mem[req.taps[k].addr] : '0;
            end
            rd.full <= req.full;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= req_valid;
        end
    end

    // the image must not change under a running scan
    assert property (@(posedge clk) disable iff (!rst) pix_we |-> !busy)
        else $error("pixel write while busy");

    assert property (@(posedge clk) disable iff (!rst) pix_we |-> pix_waddr < NUM_PIX)
        else $error("pixel write address outside the image");

endmodule

// File: patch_addr_gen.sv
module patch_addr_gen import conv_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               addr_strobe,
    input  logic [COORD_W-1:0] row,
    input  logic [COORD_W-1:0] col,
    output logic               req_valid,
    output patch_req_t         req
);

    logic [COORD_W-1:0] prev_row;
    logic full_now;
    tap_t [TAPS-1:0] tap_now;

    // builds one tap from the output position and the tap index
    // taps outside the image keep address zero and are flagged so the memory returns zero
    function automatic tap_t make_tap(
        input logic [COORD_W-1:0] r0,
        input logic [COORD_W-1:0] c0,
        input int                 k
    );
        tap_t t;
        int r;
        int c;
        r = int'(r0) + DIL * (k % K) - PAD;
        c = int'(c0) + DIL * (k / K) - PAD;
        t.in_img = (r >= 0) && (r < IMG_H) && (c >= 0) && (c < IMG_W);
        t.addr = t.in_img ? ADDR_W'(r * IMG_W + c) : '0;
        return t;
    endfunction

    always_comb
    begin
        for (int k = 0; k < TAPS; k++)
        begin
            tap_now[k] = make_tap(row, col, k);
        end
    end

    // the row of this same strobe decides the full load, so the first position of a row
    // is never served from the previous row's window
    // column 1 also loads in full, because its middle column was not among the three
    // columns fetched at column 0
    assign full_now = (row != prev_row) || (col == COORD_W'(DIL - 1));

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            req_valid <= 1'b0;
            // 28 is no real row, so the first strobe after reset loads in full
            prev_row <= COORD_W'(IMG_H);
        end
        else
        begin
            req_valid <= addr_strobe;
            if (addr_strobe)
            begin
                prev_row <= row;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (addr_strobe)
        begin
            req.full <= full_now;
            // the right column is fetched every cycle
            // the other six taps only matter on a full load and are left alone otherwise
            for (int k = 0; k < TAPS; k++)
            begin
                if (k >= 2 * K || full_now)
                begin
                    req.taps[k] <= tap_now[k];
                end
            end
        end
    end

    // an out-of-range position would alias into the image
    assert property (@(posedge clk) disable iff (!rst)
        addr_strobe |-> (row < IMG_H) && (col < IMG_W))
        else $error("addr_strobe with row or col outside the image");

endmodule

// File: conv_ctrl.sv
module conv_ctrl import conv_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    output logic               busy,
    output logic               done,
    output logic               addr_strobe,
    output logic [COORD_W-1:0] row,
    output logic [COORD_W-1:0] col
);

    typedef enum logic
    {
        S_IDLE,
        S_RUN
    } state_t;

    state_t state;
    logic [DRAIN_W-1:0] drain_cnt;
    logic last_col;
    logic last_row;

    assign last_col = (col == COORD_W'(IMG_W - 1));
    assign last_row = (row == COORD_W'(IMG_H - 1));

    // busy covers both the scan and the drain of the pipeline
    assign busy = (state == S_RUN);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= S_IDLE;
            addr_strobe <= 1'b0;
            row <= '0;
            col <= '0;
            drain_cnt <= '0;
            done <= 1'b0;
        end
        else
        begin
            // done is a single-cycle pulse
            done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    // a start seen here begins the scan in the next cycle at (0,0)
                    if (start)
                    begin
                        state <= S_RUN;
                        addr_strobe <= 1'b1;
                        row <= '0;
                        col <= '0;
                    end
                end
                S_RUN:
                begin
                    // start is not looked at here, so a second pulse cannot restart the scan
                    if (addr_strobe)
                    begin
                        if (last_col)
                        begin
                            col <= '0;
                            if (last_row)
                            begin
                                // last position issued, now wait for the pipeline to empty
                                addr_strobe <= 1'b0;
                                drain_cnt <= DRAIN_W'(PIPE_LAT - 1);
                            end
                            else
                            begin
                                row <= row + 1'b1;
                            end
                        end
                        else
                        begin
                            col <= col + 1'b1;
                        end
                    end
                    else if (drain_cnt == '0)
                    begin
                        // the last result leaves the MAC in this cycle
                        state <= S_IDLE;
                        done <= 1'b1;
                    end
                    else
                    begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // the downstream stages rely on strobes only inside a run
    assert property (@(posedge clk) disable iff (!rst) addr_strobe |-> busy)
        else $error("addr_strobe high while busy is low");

    // a start during a run must not bring the scan back to (0,0)
    assert property (@(posedge clk) disable iff (!rst)
        (start && busy) |=> !(addr_strobe && row == '0 && col == '0))
        else $error("start during busy restarted the scan");

endmodule

// File: conv_pkg.sv
package conv_pkg;

    // image geometry, one 28 by 28 plane of unsigned pixels
    localparam int IMG_H = 28;
    localparam int IMG_W = 28;
    localparam int NUM_PIX = IMG_H * IMG_W;

    // kernel geometry
    // a 3 by 3 kernel with dilation two, padded so the output stays 28 by 28
    localparam int K = 3;
    localparam int TAPS = K * K;
    localparam int DIL = 2;
    localparam int PAD = 2;

    // the window has to remember every column that lies between its left and right taps
    // with dilation two that is five columns, only three of which feed the MAC at a time
    localparam int HIST_COLS = DIL * (K - 1) + 1;

    // address and coordinate widths
    localparam int ADDR_W = 10;
    localparam int COORD_W = 5;
    localparam int IDX_W = 4;

    // data widths
    // pixels are unsigned and weights signed, so a product needs one extra bit
    localparam int PIX_W = 8;
    localparam int WGT_W = 8;
    localparam int PROD_W = PIX_W + WGT_W + 1;
    // nine products of at most 255 * 128 sum to 293760 in magnitude, well inside 20 bits
    localparam int ACC_W = 20;

    // cycles from an address strobe to its result
    // address gen, memory, window and two MAC stages
    localparam int PIPE_LAT = 5;
    localparam int DRAIN_W = 3;

    // one kernel tap as seen by the memory
    typedef struct packed {
        logic              in_img;
        logic [ADDR_W-1:0] addr;
    } tap_t;

    // request from the address generator, full marks a row start
    typedef struct packed {
        tap_t [TAPS-1:0] taps;
        logic            full;
    } patch_req_t;

    // pixels read for one request, with the full flag carried along
    typedef struct packed {
        logic [TAPS-1:0][PIX_W-1:0] pix;
        logic                       full;
    } patch_pix_t;

    // the nine pixels under the kernel, in tap order
    typedef struct packed {
        logic [TAPS-1:0][PIX_W-1:0] pix;
    } window_t;

endpackage
